//--- testbench/board_cases.txt
# op addr data | op mode | op (frame start) | P hcount vcount in_rgb expected_rgb, all hex
# Board at x 0x64, y 0x32, 0x200 wide. Cell byte: mine flag uncovered spare count[3:0].
S 00 0064
S 01 0032
S 02 0200
C 11 0020
C 21 0021
C 22 0022
C 23 0023
C 24 0024
C 25 0025
C 26 0026
C 27 0027
C 28 0028
C 31 0040
C 32 00A0
C 33 0080
# Menu mode passes everything.
P 0C8 064 123 123
P 06E 03C 456 456
M 1
F
# Covered cell 0,0 and the board edges.
P 06E 03C 5A5 CCC
P 064 032 5A5 FFF
P 065 034 5A5 777
P 063 03C 5A5 5A5
P 064 03C 5A5 777
P 263 03C 5A5 FFF
P 264 03C 5A5 5A5
P 06E 031 5A5 5A5
P 06E 231 5A5 777
P 06E 232 5A5 5A5
# Uncovered zero, then digits 1 to 8.
P 084 05C 5A5 888
P 08E 05C 5A5 BBB
P 092 07A 5A5 00F
P 08C 07A 5A5 BBB
P 0AE 086 5A5 080
P 0A4 07C 5A5 888
P 0D0 07A 5A5 F00
P 0EE 082 5A5 008
P 10E 07A 5A5 800
P 12E 07E 5A5 088
P 158 07A 5A5 000
P 16E 07C 5A5 444
P 16C 088 5A5 BBB
# Flag, uncovered mine, covered mine.
P 09A 09E 5A5 F00
P 08C 09A 5A5 CCC
P 085 0A6 5A5 777
P 0AC 0A0 5A5 000
P 0AC 09A 5A5 BBB
P 0C3 0A6 5A5 888
P 0CE 09C 5A5 CCC
# Cell 4,0 uncovered by the host, visible after the next frame.
C 40 0020
P 06E 0BC 5A5 CCC
P 064 0B7 5A5 777
F
P 06E 0BC 5A5 BBB
P 064 0B7 5A5 888
# Board moves to x 0xC8, y 0x64 only after menu and play again.
S 00 00C8
S 01 0064
P 06E 03C 5A5 CCC
M 0
P 0D2 06E 5A5 5A5
M 1
P 06E 03C 5A5 5A5
P 0C7 06E 5A5 5A5
P 0C8 06E 5A5 777
P 0D2 06E 5A5 CCC
P 0D2 0EE 5A5 BBB
M 2
P 0D2 06E 5A5 CCC

//--- compile.f
+incdir+design
design/board_pkg.sv
design/wb_store.sv
design/wb_read_master.sv
design/glyph_painter.sv
design/board_renderer.sv
design/minesweeper_board_top.sv
testbench/board_checker.sv
testbench/board_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= board_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
CASES     ?= testbench/board_cases.txt
VFLAGS    ?= --binary -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(CASES)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS PASSED" $(LOG); then echo "Simulation passed"; \
	else echo "Simulation failed, see $(LOG)"; exit 1; fi

check: run

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/board_tb.sv
module board_tb;

  typedef struct packed {
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
  } cmd_t;

  localparam string CASES_FILE = "testbench/board_cases.txt";

  logic                  clk;
  logic                  rst;
  board_pkg::game_mode_t mode;
  board_pkg::host_wr_t   host_wr;
  board_pkg::vga_bus_t   vga_in;
  board_pkg::vga_bus_t   vga_out;
  logic                  probe_valid;
  logic [11:0]           probe_rgb;
  int                    error_count;
  int                    probe_count;
  int                    pending_count;

  cmd_t cmds[$];
  int   cycle_limit = 500;
  int   cycle_count = 0;
  logic limit_ready = 1'b0;

  minesweeper_board_top minesweeper_board_top_inst (
    .clk     (clk),
    .rst     (rst),
    .mode    (mode),
    .host_wr (host_wr),
    .vga_in  (vga_in),
    .vga_out (vga_out)
  );

  board_checker board_checker_inst (
    .clk           (clk),
    .rst           (rst),
    .vga_in        (vga_in),
    .vga_out       (vga_out),
    .probe_valid   (probe_valid),
    .probe_rgb     (probe_rgb),
    .error_count   (error_count),
    .probe_count   (probe_count),
    .pending_count (pending_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  task automatic next_cycle();
    @(posedge clk);
    #2; // Inputs change just after the edge.
  endtask

  // Blanked pixel far from any probe and from the frame start.
  function automatic board_pkg::vga_bus_t idle_pixel();
    board_pkg::vga_bus_t v;
    v        = '0;
    v.hcount = 11'h7FF;
    v.vcount = 11'h7FF;
    v.hblnk  = 1'b1;
    v.vblnk  = 1'b1;
    return v;
  endfunction

  task automatic read_cases();
    int          fd;
    int          n;
    string       line;
    cmd_t        cmd;
    logic [31:0] a, b, c, d;
    fd = $fopen(CASES_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the case file %s", CASES_FILE);
      $display("TESTS FAILED");
      $finish;
    end
    while (!$feof(fd)) begin
      line = "";
      n    = $fgets(line, fd);
      if (n > 0 && line.len() > 0) begin
        cmd    = '0;
        cmd.op = line.getc(0);
        if (cmd.op inside {"S", "C", "M", "F", "P"}) begin
          a = '0;
          b = '0;
          c = '0;
          d = '0;
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d);
          cmd.a = a;
          cmd.b = b;
          cmd.c = c;
          cmd.d = d;
          cmds.push_back(cmd);
        end
      end
    end
    $fclose(fd);
    foreach (cmds[i]) cycle_limit += (cmds[i].op == "F") ? 1000 : 20;
  endtask

  task automatic run_command(input cmd_t cmd);
    case (cmd.op)
      "S", "C": begin
        host_wr.we  = 1'b1;
        host_wr.sel = (cmd.op == "C");
        host_wr.adr = cmd.a[7:0];
        host_wr.dat = cmd.b[15:0];
        next_cycle();
        host_wr = '0;
      end
      "M": begin
        mode = board_pkg::game_mode_t'(cmd.a[1:0]);
        repeat (11) next_cycle(); // Drawing starts 10 cycles after the first read.
      end
      "F": begin
        vga_in = '0;
        next_cycle();
        vga_in = idle_pixel();
        repeat (800) next_cycle();
      end
      "P": begin
        vga_in        = '0;
        vga_in.hcount = cmd.a[10:0];
        vga_in.vcount = cmd.b[10:0];
        vga_in.hsync  = cmd.a[0];
        vga_in.vsync  = cmd.b[0];
        vga_in.rgb    = cmd.c[11:0];
        probe_valid   = 1'b1;
        probe_rgb     = cmd.d[11:0];
        next_cycle();
        vga_in      = idle_pixel();
        probe_valid = 1'b0;
      end
      default: ;
    endcase
  endtask

  initial begin
    rst         = 1'b1;
    mode        = board_pkg::MODE_MENU;
    host_wr     = '0;
    vga_in      = idle_pixel();
    probe_valid = 1'b0;
    probe_rgb   = '0;
    read_cases();
    limit_ready = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    foreach (cmds[i]) run_command(cmds[i]);
    repeat (4) next_cycle();
    if (pending_count != 0) $display("%0d probes never appeared on vga_out", pending_count);
    $display("Probes checked: %0d, errors: %0d", probe_count, error_count + pending_count);
    if (error_count == 0 && pending_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (limit_ready);
    while (cycle_count < cycle_limit) @(posedge clk);
    $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
    $display("Probes checked: %0d, errors: %0d", probe_count, error_count);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- testbench/board_checker.sv
module board_checker (
  input  logic                clk,
  input  logic                rst,
  input  board_pkg::vga_bus_t vga_in,
  input  board_pkg::vga_bus_t vga_out,
  input  logic                probe_valid,
  input  logic [11:0]         probe_rgb,
  output int                  error_count,
  output int                  probe_count,
  output int                  pending_count
);

  typedef struct packed {
    logic [10:0] hcount;
    logic [10:0] vcount;
    logic [11:0] rgb;
    logic [31:0] due;
  } probe_t;

  probe_t              probes[$];
  board_pkg::vga_bus_t in_d1;
  board_pkg::vga_bus_t in_d2;
  logic [31:0]         sample = '0;
  int                  valid = 0;

  initial begin
    error_count   = 0;
    probe_count   = 0;
    pending_count = 0;
  end

  function automatic logic [25:0] timing_fields(input board_pkg::vga_bus_t v);
    return {v.hcount, v.vsync, v.hblnk, v.vcount, v.hsync, v.vblnk};
  endfunction

  // Sampled mid-cycle, away from the driving edge.
  always @(negedge clk) begin
    probe_t p;
    if (rst) begin
      valid = 0;
    end else begin
      if (valid >= 2 && timing_fields(vga_out) !== timing_fields(in_d2)) begin
        error_count++;
        $display("Error: vga_out timing fields 0x%h, expected 0x%h",
                 timing_fields(vga_out), timing_fields(in_d2));
      end
      if (probes.size() > 0 && probes[0].due == sample) begin
        p = probes.pop_front();
        probe_count++;
        if (vga_out.hcount !== p.hcount || vga_out.vcount !== p.vcount) begin
          error_count++;
          $display("Probe at hcount 0x%h vcount 0x%h did not appear on vga_out two cycles later",
                   p.hcount, p.vcount);
        end else if (vga_out.rgb !== p.rgb) begin
          error_count++;
          $display("Error: vga_out.rgb at hcount 0x%h vcount 0x%h is 0x%h, expected 0x%h",
                   p.hcount, p.vcount, vga_out.rgb, p.rgb);
        end
      end
      if (probe_valid) begin
        probes.push_back({vga_in.hcount, vga_in.vcount, probe_rgb, sample + 32'd2});
      end
      in_d2 = in_d1; // Two-cycle pipeline model.
      in_d1 = vga_in;
      if (valid < 2) valid++;
      sample++;
    end
    pending_count = probes.size();
  end

endmodule

//--- design/minesweeper_board_top.sv
`include "board_defines.svh"

module minesweeper_board_top (
  input  logic                  clk,
  input  logic                  rst,
  input  board_pkg::game_mode_t mode,
  input  board_pkg::host_wr_t   host_wr,
  input  board_pkg::vga_bus_t   vga_in,
  output board_pkg::vga_bus_t   vga_out
);

  board_pkg::wb_req_t settings_req;
  board_pkg::wb_req_t board_req;
  board_pkg::wb_rsp_t settings_rsp;
  board_pkg::wb_rsp_t board_rsp;

  wb_store #(
    .word_t (logic [15:0]),
    .DEPTH  (`SETTINGS_WORDS)
  ) settings_store (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (host_wr.we && !host_wr.sel),
    .wr_addr (host_wr.adr),
    .wr_data (host_wr.dat),
    .req     (settings_req),
    .rsp     (settings_rsp)
  );

  wb_store #(
    .word_t (board_pkg::cell_t),
    .DEPTH  (`BOARD_CELLS * `BOARD_CELLS)
  ) board_store (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (host_wr.we && host_wr.sel),
    .wr_addr (host_wr.adr),
    .wr_data (board_pkg::cell_t'(host_wr.dat[7:0])),
    .req     (board_req),
    .rsp     (board_rsp)
  );

  board_renderer renderer (
    .clk          (clk),
    .rst          (rst),
    .mode         (mode),
    .vga_in       (vga_in),
    .vga_out      (vga_out),
    .settings_req (settings_req),
    .settings_rsp (settings_rsp),
    .board_req    (board_req),
    .board_rsp    (board_rsp)
  );

endmodule

//--- design/board_renderer.sv
`include "board_defines.svh"

module board_renderer (
  input  logic                  clk,
  input  logic                  rst,
  input  board_pkg::game_mode_t mode,
  input  board_pkg::vga_bus_t   vga_in,
  output board_pkg::vga_bus_t   vga_out,
  output board_pkg::wb_req_t    settings_req,
  input  board_pkg::wb_rsp_t    settings_rsp,
  output board_pkg::wb_req_t    board_req,
  input  board_pkg::wb_rsp_t    board_rsp
);

  localparam int IDX_W = $clog2(`BOARD_CELLS);

  typedef enum logic [1:0] {
    SET_IDLE,
    SET_LOAD,
    SET_DRAW
  } set_state_t;

  typedef enum logic {
    REF_WAIT,
    REF_READ
  } ref_state_t;

  set_state_t             set_state;
  ref_state_t             ref_state;
  board_pkg::board_geom_t geom;
  board_pkg::cell_t       cell_cache [`BOARD_CELLS * `BOARD_CELLS];

  logic        set_read_en, set_ready, brd_read_en, brd_ready;
  logic        set_start, brd_start;
  logic [7:0]  set_addr, brd_addr, set_rd_addr, brd_rd_addr;
  logic [15:0] set_data, brd_data;

  logic [10:0]         dx, dy;
  logic                in_rect;
  board_pkg::cell_t    cur_cell;
  logic [3:0]          glyph;
  board_pkg::vga_bus_t s1_vga;
  logic                s1_active;
  board_pkg::cell_t    s1_cell;
  logic [4:0]          s1_lx, s1_ly;
  logic                pixel_on;
  logic [11:0]         pixel_rgb, uncov_rgb, button_rgb, draw_rgb;

  // Settings load: three back-to-back reads on entry to play.
  assign set_read_en = set_start ||
                       (set_state == SET_LOAD && set_ready &&
                        set_addr != 8'(`SETTINGS_WORDS - 1));
  assign set_rd_addr = set_ready ? set_addr + 8'd1 : set_addr; // Next word in the ready cycle.

  always_ff @(posedge clk) begin
    if (rst) begin
      set_state <= SET_IDLE;
      set_start <= 1'b0;
      set_addr  <= '0;
      geom      <= '0;
    end else begin
      set_start <= 1'b0;
      case (set_state)
        SET_IDLE: begin
          if (mode == board_pkg::MODE_PLAY) begin
            set_start <= 1'b1;
            set_addr  <= '0;
            set_state <= SET_LOAD;
          end
        end
        SET_LOAD: begin
          if (set_ready) begin
            case (set_addr[1:0])
              2'd0:    geom.xpos <= set_data[10:0];
              2'd1:    geom.ypos <= set_data[10:0];
              default: geom.size <= set_data[10:0];
            endcase
            if (set_addr == 8'(`SETTINGS_WORDS - 1)) begin
              set_state <= SET_DRAW;
            end else begin
              set_addr <= set_addr + 8'd1;
            end
          end
        end
        SET_DRAW: begin
          if (mode == board_pkg::MODE_MENU) set_state <= SET_IDLE;
        end
        default: set_state <= SET_IDLE;
      endcase
    end
  end

  // Board refresh at frame start, frame starts during a refresh are ignored.
  assign brd_read_en = brd_start ||
                       (ref_state == REF_READ && brd_ready && brd_addr != 8'hFF);
  assign brd_rd_addr = brd_ready ? brd_addr + 8'd1 : brd_addr; // Next cell in the ready cycle.

  always_ff @(posedge clk) begin
    if (rst) begin
      ref_state <= REF_WAIT;
      brd_start <= 1'b0;
      brd_addr  <= '0;
      for (int i = 0; i < `BOARD_CELLS * `BOARD_CELLS; i++) begin
        cell_cache[i] <= '0;
      end
    end else begin
      brd_start <= 1'b0;
      case (ref_state)
        REF_WAIT: begin
          if (vga_in.vcount == '0 && vga_in.hcount == '0 &&
              mode != board_pkg::MODE_MENU) begin
            brd_start <= 1'b1;
            brd_addr  <= '0;
            ref_state <= REF_READ;
          end
        end
        REF_READ: begin
          if (brd_ready) begin
            cell_cache[brd_addr] <= board_pkg::cell_t'(brd_data[7:0]);
            if (brd_addr == 8'hFF) begin
              ref_state <= REF_WAIT;
            end else begin
              brd_addr <= brd_addr + 8'd1;
            end
          end
        end
        default: ref_state <= REF_WAIT;
      endcase
    end
  end

  // Stage 1 position decode.
  assign dx      = vga_in.hcount - geom.xpos;
  assign dy      = vga_in.vcount - geom.ypos;
  assign in_rect = ({1'b0, vga_in.hcount} >= {1'b0, geom.xpos}) &&
                   ({1'b0, vga_in.hcount} < {1'b0, geom.xpos} + {1'b0, geom.size}) &&
                   ({1'b0, vga_in.vcount} >= {1'b0, geom.ypos}) &&
                   ({1'b0, vga_in.vcount} < {1'b0, geom.ypos} + {1'b0, geom.size});
  assign cur_cell = cell_cache[{dy[`CELL_SHIFT +: IDX_W], dx[`CELL_SHIFT +: IDX_W]}];

  always_comb begin
    if (cur_cell.uncovered && cur_cell.mine) glyph = 4'd10;
    else if (cur_cell.uncovered) glyph = cur_cell.count;
    else if (cur_cell.flag) glyph = 4'd9;
    else glyph = 4'd0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_vga    <= '0;
      s1_active <= 1'b0;
    end else begin
      s1_vga    <= vga_in;
      s1_active <= in_rect && (set_state == SET_DRAW);
    end
  end

  always_ff @(posedge clk) begin
    s1_cell <= cur_cell;
    s1_lx   <= dx[`CELL_SHIFT-1:0];
    s1_ly   <= dy[`CELL_SHIFT-1:0];
  end

  // Stage 2 colour select.
  always_comb begin
    if (s1_lx == '0 || s1_ly == '0 || s1_lx == 5'(`CELL_PX - 1) || s1_ly == 5'(`CELL_PX - 1))
      uncov_rgb = `COL_UNCOVERED_EDGE;
    else
      uncov_rgb = `COL_UNCOVERED_BACK;
    if (s1_lx >= `MARGIN && s1_lx < `CELL_PX - `MARGIN &&
        s1_ly >= `MARGIN && s1_ly < `CELL_PX - `MARGIN)
      button_rgb = `COL_BUTTON_BACK;
    else if (s1_lx >= s1_ly)
      button_rgb = `COL_BUTTON_WHITE;
    else
      button_rgb = `COL_BUTTON_GRAY;

    if (!s1_active) draw_rgb = s1_vga.rgb;
    else if (s1_cell.uncovered && (s1_cell.mine || s1_cell.count != '0))
      draw_rgb = pixel_on ? pixel_rgb : uncov_rgb;
    else if (s1_cell.uncovered) draw_rgb = uncov_rgb;
    else if (s1_cell.flag) draw_rgb = pixel_on ? pixel_rgb : button_rgb;
    else draw_rgb = button_rgb;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vga_out <= '0;
    end else begin
      vga_out     <= s1_vga;
      vga_out.rgb <= draw_rgb;
    end
  end

  wb_read_master settings_master (
    .clk        (clk),
    .rst        (rst),
    .read_en    (set_read_en),
    .read_addr  (set_rd_addr),
    .read_data  (set_data),
    .read_ready (set_ready),
    .req        (settings_req),
    .rsp        (settings_rsp)
  );

  wb_read_master board_master (
    .clk        (clk),
    .rst        (rst),
    .read_en    (brd_read_en),
    .read_addr  (brd_rd_addr),
    .read_data  (brd_data),
    .read_ready (brd_ready),
    .req        (board_req),
    .rsp        (board_rsp)
  );

  glyph_painter painter (
    .clk       (clk),
    .glyph     (glyph),
    .local_x   (dx[`CELL_SHIFT-1:0]),
    .local_y   (dy[`CELL_SHIFT-1:0]),
    .pixel_on  (pixel_on),
    .pixel_rgb (pixel_rgb)
  );

endmodule

//--- design/glyph_painter.sv
module glyph_painter (
  input  logic        clk,
  input  logic [3:0]  glyph,
  input  logic [4:0]  local_x,
  input  logic [4:0]  local_y,
  output logic        pixel_on,
  output logic [11:0] pixel_rgb
);

  localparam logic [4:0] GLYPH_LO = 5'd8;
  localparam logic [4:0] GLYPH_HI = 5'd23;

  logic [75:0] glyph_def;
  logic [63:0] bitmap;
  logic [11:0] colour;
  logic [4:0]  off_x;
  logic [4:0]  off_y;
  logic [5:0]  bit_idx;
  logic        in_box;

  assign off_x   = local_x - GLYPH_LO;
  assign off_y   = local_y - GLYPH_LO;
  assign bit_idx = {off_y[3:1], off_x[3:1]}; // 2x scale.
  assign in_box  = (local_x >= GLYPH_LO) && (local_x <= GLYPH_HI) &&
                   (local_y >= GLYPH_LO) && (local_y <= GLYPH_HI);

  // Colour on top, then 8 rows with row 0 in the high byte.
  always_comb begin
    case (glyph)
      4'd1:    glyph_def = {12'h00F, 64'h1838181818187E00};
      4'd2:    glyph_def = {12'h080, 64'h3C66060C18307E00};
      4'd3:    glyph_def = {12'hF00, 64'h3C66061C06663C00};
      4'd4:    glyph_def = {12'h008, 64'h0C1C3C6C7E0C0C00};
      4'd5:    glyph_def = {12'h800, 64'h7E607C0606663C00};
      4'd6:    glyph_def = {12'h088, 64'h3C607C6666663C00};
      4'd7:    glyph_def = {12'h000, 64'h7E060C1830303000};
      4'd8:    glyph_def = {12'h444, 64'h3C66663C66663C00};
      4'd9:    glyph_def = {12'hF00, 64'h181E1F1E18187E00}; // Flag.
      4'd10:   glyph_def = {12'h000, 64'h105438FE38541000}; // Mine.
      default: glyph_def = '0;
    endcase
  end

  assign colour = glyph_def[75:64];
  assign bitmap = glyph_def[63:0];

  always_ff @(posedge clk) begin
    pixel_on  <= in_box && bitmap[6'd63 - bit_idx];
    pixel_rgb <= colour;
  end

endmodule

//--- design/wb_read_master.sv
module wb_read_master (
  input  logic               clk,
  input  logic               rst,
  input  logic               read_en,
  input  logic [7:0]         read_addr,
  output logic [15:0]        read_data,
  output logic               read_ready,
  output board_pkg::wb_req_t req,
  input  board_pkg::wb_rsp_t rsp
);

  typedef enum logic {
    M_IDLE,
    M_WAIT
  } state_t;

  state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= M_IDLE;
      req        <= '0;
      read_ready <= 1'b0;
    end else begin
      read_ready <= 1'b0;
      case (state)
        M_IDLE: begin
          if (read_en) begin
            req.cyc <= 1'b1;
            req.stb <= 1'b1;
            req.adr <= read_addr;
            state   <= M_WAIT;
          end
        end
        M_WAIT: begin
          if (rsp.ack) begin // Single beat, release the bus.
            req.cyc    <= 1'b0;
            req.stb    <= 1'b0;
            read_ready <= 1'b1;
            state      <= M_IDLE;
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == M_WAIT && rsp.ack) begin
      read_data <= rsp.dat;
    end
  end

endmodule

//--- design/wb_store.sv
module wb_store #(
  parameter type word_t = logic [15:0],
  parameter int  DEPTH  = 3
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              wr_en,
  input  logic [7:0]        wr_addr,
  input  word_t             wr_data,
  input  board_pkg::wb_req_t req,
  output board_pkg::wb_rsp_t rsp
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      rsp <= '0;
    end else begin
      if (wr_en && (wr_addr < DEPTH)) begin
        mem[wr_addr[AW-1:0]] <= wr_data;
      end

      // One ack per request, the master drops cyc after it.
      rsp.ack <= req.cyc && req.stb && !rsp.ack;

      if (req.adr < DEPTH) begin
        rsp.dat <= 16'(mem[req.adr[AW-1:0]]);
      end else begin
        rsp.dat <= '0; // Unmapped word.
      end
    end
  end

endmodule

//--- design/board_pkg.sv
package board_pkg;

  typedef struct packed {
    logic [10:0] hcount;
    logic        vsync;
    logic        hblnk;
    logic [10:0] vcount;
    logic        hsync;
    logic        vblnk;
    logic [11:0] rgb;
  } vga_bus_t;

  typedef struct packed {
    logic       mine;
    logic       flag;
    logic       uncovered;
    logic       spare;
    logic [3:0] count; // Neighbouring mines.
  } cell_t;

  typedef enum logic [1:0] {
    MODE_MENU = 2'd0,
    MODE_PLAY = 2'd1,
    MODE_OVER = 2'd2
  } game_mode_t;

  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic [7:0] adr;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [15:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic [10:0] xpos;
    logic [10:0] ypos;
    logic [10:0] size;
  } board_geom_t;

  typedef struct packed {
    logic        we;
    logic        sel; // 0 settings, 1 board.
    logic [7:0]  adr;
    logic [15:0] dat;
  } host_wr_t;

endpackage

//--- design/board_defines.svh
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// Cell geometry.
`define CELL_PX 32
`define CELL_SHIFT 5
`define BOARD_CELLS 16

// Settings registers: x position, y position, board size.
`define SETTINGS_WORDS 3

// Bevel width of a covered button.
`define MARGIN 4

// 12-bit RGB palette.
`define COL_BUTTON_BACK 12'hCCC
`define COL_BUTTON_WHITE 12'hFFF
`define COL_BUTTON_GRAY 12'h777
`define COL_UNCOVERED_BACK 12'hBBB
`define COL_UNCOVERED_EDGE 12'h888

`endif
